// ==== bench/tb_rmii_top.sv ====
/*
 * loopback testbench for the multi-channel RMII link layer
 * frame table on tx looped back to rx, odd-dibit frames driven directly
 */
`timescale 1ns/1ps

module tb_rmii_top;

    import rmii_pkg::*;

    localparam int CHANNELS   = 4;
    localparam int IFG_BYTES  = 12;
    localparam int NUM_FRAMES = 10;
    localparam int WAIT_LIMIT = 400;

    // table entry with channel, payload length and trailing odd dibit flag
    typedef struct packed {
        logic [1:0] ch;
        logic [4:0] len;
        logic       odd;
    } frame_t;

    logic     clk;
    logic     rst_n;
    rmii_rx_t rmii_rx   [CHANNELS];
    rmii_tx_t rmii_tx   [CHANNELS];
    rx_beat_t rx_beat   [CHANNELS];
    tx_beat_t tx_beat   [CHANNELS];
    logic     tx_valid  [CHANNELS];
    logic     tx_ready  [CHANNELS];
    logic     bypass    [CHANNELS];
    rmii_rx_t direct_rx [CHANNELS];
    rx_beat_t exp_q     [CHANNELS][$];
    frame_t   frames    [NUM_FRAMES];
    int       gap_cnt   [CHANNELS];
    logic     seen_fall [CHANNELS];
    logic     txen_prev [CHANNELS];
    integer   seed;
    int       err_cnt;
    int       timeout_cnt;
    int       rx_cnt;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    rmii_top #(
        .CHANNELS  (CHANNELS),
        .IFG_BYTES (IFG_BYTES)
    ) i_rmii_top (
        .i_top      (clk),
        .i_rst_n    (rst_n),
        .i_rmii_rx  (rmii_rx),
        .o_rmii_tx  (rmii_tx),
        .o_rx_beat  (rx_beat),
        .i_tx_beat  (tx_beat),
        .i_tx_valid (tx_valid),
        .o_tx_ready (tx_ready)
    );

    // board loopback copies txen to crs_dv and txd to rxd
    for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_loop
        assign rmii_rx[ch] = bypass[ch] ? direct_rx[ch]
                                        : rmii_rx_t'({rmii_tx[ch].txen, rmii_tx[ch].txd});
    end

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_byte(input int ch, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t: ch%0d rx data %02h, expected %02h", $time, ch, got, exp);
        end
    endtask

    task automatic check_beat(input int ch, input rx_beat_t got, input rx_beat_t exp);
        if ({got.first, got.last} !== {exp.first, exp.last}) begin
            err_cnt++;
            $display("error at %0t: ch%0d rx flags f/l %b%b, expected %b%b", $time, ch,
                     got.first, got.last, exp.first, exp.last);
        end
    endtask

    task automatic check_tx(input int ch, input int idx, input rmii_tx_t got, input rmii_tx_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t: ch%0d tx pins at dibit %0d are %b/%b, expected %b/%b",
                     $time, ch, idx, got.txen, got.txd, exp.txen, exp.txd);
        end
    endtask

    task automatic check_flag(input int ch, input string what, input logic got, input logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t: ch%0d %s is %b, expected %b", $time, ch, what, got, exp);
        end
    endtask

    // --------------------------------------------------
    // monitors sampled mid-cycle
    // --------------------------------------------------
    always @(negedge clk) begin
        rx_beat_t want;
        for (int ch = 0; ch < CHANNELS; ch++) begin
            if (rst_n && rx_beat[ch].valid) begin
                if (exp_q[ch].size() == 0) begin
                    err_cnt++;
                    $display("unexpected byte %02h on channel %0d at %0t",
                             rx_beat[ch].data, ch, $time);
                end else begin
                    want = exp_q[ch].pop_front();
                    check_byte(ch, rx_beat[ch].data, want.data);
                    check_beat(ch, rx_beat[ch], want);
                    rx_cnt++;
                end
            end
            // low clocks between a fall of txen and its next rise
            if (rmii_tx[ch].txen) begin
                if (!txen_prev[ch] && seen_fall[ch] && gap_cnt[ch] < IFG_BYTES * 4) begin
                    err_cnt++;
                    $display("error at %0t: ch%0d gap of %0d clocks, expected at least %0d",
                             $time, ch, gap_cnt[ch], IFG_BYTES * 4);
                end
                gap_cnt[ch] = 0;
            end else begin
                seen_fall[ch] = seen_fall[ch] || txen_prev[ch];
                gap_cnt[ch]++;
            end
            txen_prev[ch] = rmii_tx[ch].txen;
        end
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    // offer a random frame and follow every pin dibit until txen drops
    task automatic send_frame(input int ch, input int len);
        byte_t    payload [$];
        rx_beat_t beat;
        rmii_tx_t want;
        int       k;
        int       idx;
        int       cycles;
        logic     started;
        logic     hit;
        for (int i = 0; i < len; i++) begin
            payload.push_back(byte_t'($random(seed)));
            beat = '{valid: 1'b1, first: (i == 0), last: (i == len - 1), data: payload[i]};
            exp_q[ch].push_back(beat);
        end
        @(posedge clk);
        tx_beat[ch]  <= '{last: (len == 1), data: payload[0]};
        tx_valid[ch] <= 1'b1;
        k = 0;
        idx = 0;
        cycles = 0;
        started = 1'b0;
        while (k <= 32 + 4 * len) begin
            // 31 x 01 then 11 then payload lsb dibit first and idle pins after
            if (!started || k >= 32 + 4 * len) want = '0;
            else if (k < 31) want = '{txen: 1'b1, txd: 2'b01};
            else if (k == 31) want = '{txen: 1'b1, txd: 2'b11};
            else want = '{txen: 1'b1, txd: dibit_t'(payload[(k - 32) / 4] >> (2 * (k % 4)))};
            @(negedge clk);
            check_tx(ch, started ? k : -1, rmii_tx[ch], want);
            k = started ? k + 1 : k;
            hit = tx_valid[ch] && tx_ready[ch];
            @(posedge clk);
            if (hit) begin
                started = 1'b1;
                idx++;
                if (idx < len) tx_beat[ch] <= '{last: (idx == len - 1), data: payload[idx]};
                else tx_valid[ch] <= 1'b0;
            end
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                timeout_cnt++;
                $display("timeout: channel %0d did not finish a %0d byte frame", ch, len);
                tx_valid[ch] <= 1'b0;
                return;
            end
        end
    endtask

    task automatic drive_dibit(input int ch, input dibit_t d);
        @(posedge clk);
        direct_rx[ch] <= '{crs_dv: 1'b1, rxd: d};
    endtask

    task automatic wait_rx_drain(input int ch);
        int cycles;
        cycles = 0;
        while (exp_q[ch].size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                timeout_cnt++;
                $display("timeout: channel %0d still waits for %0d bytes", ch, exp_q[ch].size());
                return;
            end
        end
    endtask

    // whole bytes plus one stray dibit straight onto the rx pins
    task automatic send_odd(input int ch, input int len);
        byte_t    cur;
        rx_beat_t beat;
        @(posedge clk);
        bypass[ch]    <= 1'b1;
        direct_rx[ch] <= '0;
        for (int i = 0; i < 31; i++) drive_dibit(ch, 2'b01);
        drive_dibit(ch, 2'b11);
        for (int i = 0; i < len; i++) begin
            cur = byte_t'($random(seed));
            // stray dibit keeps carrier up so the final byte leaves with last low
            beat = '{valid: 1'b1, first: (i == 0), last: 1'b0, data: cur};
            exp_q[ch].push_back(beat);
            for (int j = 0; j < 4; j++) drive_dibit(ch, cur[2 * j +: 2]);
        end
        drive_dibit(ch, dibit_t'($random(seed)));
        @(posedge clk);
        direct_rx[ch] <= '0;
        wait_rx_drain(ch);
        @(posedge clk);
        bypass[ch] <= 1'b0;
    endtask

    initial begin
        seed = 32'h74a15175;
        err_cnt = 0;
        timeout_cnt = 0;
        rx_cnt = 0;
        rst_n = 1'b0;
        for (int ch = 0; ch < CHANNELS; ch++) begin
            tx_beat[ch] = '0;
            tx_valid[ch] = 1'b0;
            bypass[ch] = 1'b0;
            direct_rx[ch] = '0;
            gap_cnt[ch] = 0;
            seen_fall[ch] = 1'b0;
            txen_prev[ch] = 1'b0;
        end
        // back-to-back entries on one channel exercise the gap
        frames[0] = '{ch: 2'd0, len: 5'd1,  odd: 1'b0};
        frames[1] = '{ch: 2'd0, len: 5'd20, odd: 1'b0};
        frames[2] = '{ch: 2'd1, len: 5'd7,  odd: 1'b0};
        frames[3] = '{ch: 2'd1, len: 5'd3,  odd: 1'b1};
        frames[4] = '{ch: 2'd2, len: 5'd12, odd: 1'b0};
        frames[5] = '{ch: 2'd2, len: 5'd2,  odd: 1'b0};
        frames[6] = '{ch: 2'd3, len: 5'd16, odd: 1'b0};
        frames[7] = '{ch: 2'd3, len: 5'd5,  odd: 1'b1};
        frames[8] = '{ch: 2'd0, len: 5'd9,  odd: 1'b0};
        frames[9] = '{ch: 2'd1, len: 5'd1,  odd: 1'b1};
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        for (int ch = 0; ch < CHANNELS; ch++) begin
            check_flag(ch, "txen", rmii_tx[ch].txen, 1'b0);
            check_flag(ch, "rx valid", rx_beat[ch].valid, 1'b0);
            check_flag(ch, "tx ready", tx_ready[ch], 1'b0);
        end
        for (int f = 0; f < NUM_FRAMES && timeout_cnt == 0; f++) begin
            if (frames[f].odd) begin
                wait_rx_drain(int'(frames[f].ch));
                send_odd(int'(frames[f].ch), int'(frames[f].len));
            end else begin
                send_frame(int'(frames[f].ch), int'(frames[f].len));
            end
        end
        // all channels at once with no mixing between them
        if (timeout_cnt == 0) begin
            fork
                send_frame(0, 20);
                send_frame(1, 13);
                send_frame(2, 5);
                send_frame(3, 1);
            join
        end
        for (int ch = 0; ch < CHANNELS; ch++) wait_rx_drain(ch);
        $display("summary: %0d rx bytes checked, %0d errors, %0d timeouts",
                 rx_cnt, err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
src/rmii_pkg.sv
src/rmii_rx.sv
src/rmii_tx.sv
src/rmii_top.sv
bench/tb_rmii_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the RMII loopback testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -j 0 -Wno-fatal --top-module tb_rmii_top -f files.f -o sim_rmii

./obj_dir/sim_rmii > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

// ==== src/rmii_pkg.sv ====
/*
 * RMII link layer shared definitions
 * pin bundles, byte beats and the framing constants used by rx and tx
 */
package rmii_pkg;

    // --------------------------------------------------
    // widths with a meaning
    // --------------------------------------------------
    // one octet of frame data
    typedef logic [7:0] byte_t;
    // one rmii symbol, two bits per reference clock
    typedef logic [1:0] dibit_t;

    // --------------------------------------------------
    // pin bundles, one channel each
    // --------------------------------------------------
    typedef struct packed {
        logic   crs_dv;
        dibit_t rxd;
    } rmii_rx_t;

    typedef struct packed {
        logic   txen;
        dibit_t txd;
    } rmii_tx_t;

    // --------------------------------------------------
    // byte beats
    // --------------------------------------------------
    // received byte, valid is a single-cycle pulse
    typedef struct packed {
        logic  valid;
        logic  first;
        logic  last;
        byte_t data;
    } rx_beat_t;

    // byte offered to the transmitter, valid/ready live outside
    typedef struct packed {
        logic  last;
        byte_t data;
    } tx_beat_t;

    // framing: 7 x 55 then d5, all lsb dibit first
    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;
    localparam int    PREAMBLE_LEN  = 7;

endpackage

// ==== src/rmii_rx.sv ====
/*
 * RMII receiver, one channel
 * hunts for preamble and sfd, packs dibits into bytes lsb first
 * and emits one beat per byte with first/last flags
 */
`timescale 1ns/1ps

module rmii_rx (
    input  logic               i_top,
    input  logic               i_rst_n,
    input  rmii_pkg::rmii_rx_t i_rmii,
    output rmii_pkg::rx_beat_t o_beat
);

    import rmii_pkg::*;

    typedef enum logic [1:0] {
        HUNT,
        SFD,
        DATA
    } state_t;

    state_t     state_q;
    logic [1:0] cnt_q;
    logic       pend_q;
    logic       first_q;
    logic       beat_valid_q;

    // shift register and beat payload
    logic [5:0] sh_q;
    byte_t      pend_data_q;
    logic       beat_first_q;
    logic       beat_last_q;
    byte_t      beat_data_q;

    logic       crs;
    dibit_t     rxd;
    logic       in_data;
    logic       byte_done;
    logic       emit;

    assign crs     = i_rmii.crs_dv;
    assign rxd     = i_rmii.rxd;
    assign in_data = (state_q == DATA);

    // fourth dibit of a byte sampled while carrier is still up
    assign byte_done = in_data && crs && (cnt_q == 2'd3);

    // held byte goes out on the very next sample
    // crs high there means more data follows, low means end of frame
    assign emit = in_data && pend_q;

    // --------------------------------------------------
    // control
    // --------------------------------------------------
    always_ff @(posedge i_top or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q      <= HUNT;
            cnt_q        <= 2'd0;
            pend_q       <= 1'b0;
            first_q      <= 1'b0;
            beat_valid_q <= 1'b0;
        end else begin
            pend_q       <= byte_done;
            beat_valid_q <= emit;
            case (state_q)
                HUNT: begin
                    // wait for a preamble dibit under carrier
                    if (crs && (rxd == 2'b01)) begin
                        state_q <= SFD;
                    end
                end
                SFD: begin
                    if (!crs) begin
                        state_q <= HUNT;
                    end else if (rxd == 2'b11) begin
                        // delimiter done so the next dibit is data
                        state_q <= DATA;
                        cnt_q   <= 2'd0;
                        first_q <= 1'b1;
                    end else if (rxd != 2'b01) begin
                        // garbage before the delimiter
                        state_q <= HUNT;
                    end
                end
                DATA: begin
                    if (!crs) begin
                        // carrier gone so a partial byte is dropped
                        state_q <= HUNT;
                    end else begin
                        cnt_q <= cnt_q + 2'd1;
                    end
                    if (emit) begin
                        first_q <= 1'b0;
                    end
                end
                default: state_q <= HUNT;
            endcase
        end
    end

    // --------------------------------------------------
    // datapath
    // --------------------------------------------------
    always_ff @(posedge i_top) begin
        // lsb dibit arrives first so shift in from the top
        if (in_data && crs) begin
            sh_q <= {rxd, sh_q[5:2]};
        end
        if (byte_done) begin
            pend_data_q <= {rxd, sh_q};
        end
        if (emit) begin
            beat_first_q <= first_q;
            beat_last_q  <= !crs;
            beat_data_q  <= pend_data_q;
        end
    end

    assign o_beat = '{
        valid: beat_valid_q,
        first: beat_first_q,
        last:  beat_last_q,
        data:  beat_data_q
    };

endmodule

// ==== src/rmii_top.sv ====
/*
 * multi-channel RMII link layer
 * CHANNELS independent receiver/transmitter pairs on one reference clock
 */
`timescale 1ns/1ps

module rmii_top #(
    parameter int CHANNELS  = 4,
    parameter int IFG_BYTES = 12
) (
    input  logic               i_top,
    input  logic               i_rst_n,

    // pins, one bundle per channel
    input  rmii_pkg::rmii_rx_t i_rmii_rx [CHANNELS],
    output rmii_pkg::rmii_tx_t o_rmii_tx [CHANNELS],

    // receive beats
    output rmii_pkg::rx_beat_t o_rx_beat [CHANNELS],

    // transmit stream
    input  rmii_pkg::tx_beat_t i_tx_beat  [CHANNELS],
    input  logic               i_tx_valid [CHANNELS],
    output logic               o_tx_ready [CHANNELS]
);

    // --------------------------------------------------
    // per-channel pairs
    // --------------------------------------------------
    // channels share only clock and reset
    for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_ch

        // rmii dibits to byte beats
        rmii_rx i_rmii_rx_ch (
            .i_top   (i_top),
            .i_rst_n (i_rst_n),
            .i_rmii  (i_rmii_rx[ch]),
            .o_beat  (o_rx_beat[ch])
        );

        // byte stream to rmii dibits with preamble and gap
        rmii_tx #(
            .IFG_BYTES (IFG_BYTES)
        ) i_rmii_tx_ch (
            .i_top   (i_top),
            .i_rst_n (i_rst_n),
            .i_beat  (i_tx_beat[ch]),
            .i_valid (i_tx_valid[ch]),
            .o_ready (o_tx_ready[ch]),
            .o_rmii  (o_rmii_tx[ch])
        );

    end

endmodule

// ==== src/rmii_tx.sv ====
/*
 * RMII transmitter, one channel
 * sends preamble and sfd through the data serializer, then the payload
 * lsb dibit first, then holds txen low for the inter-frame gap
 */
`timescale 1ns/1ps

module rmii_tx #(
    parameter int IFG_BYTES = 12
) (
    input  logic               i_top,
    input  logic               i_rst_n,
    input  rmii_pkg::tx_beat_t i_beat,
    input  logic               i_valid,
    output logic               o_ready,
    output rmii_pkg::rmii_tx_t o_rmii
);

    import rmii_pkg::*;

    // --------------------------------------------------
    // counter sizing
    // --------------------------------------------------
    localparam int PRE_DIBITS = (PREAMBLE_LEN + 1) * 4;
    localparam int GAP_CLKS   = IFG_BYTES * 4;
    localparam int CNT_W      = $clog2((GAP_CLKS > PRE_DIBITS) ? GAP_CLKS : PRE_DIBITS);

    // cnt holds the index of the dibit currently on the wire
    localparam logic [CNT_W-1:0] SFD_LOAD = CNT_W'(PREAMBLE_LEN * 4 - 1);
    localparam logic [CNT_W-1:0] PRE_LAST = CNT_W'(PRE_DIBITS - 1);
    localparam logic [CNT_W-1:0] GAP_LAST = CNT_W'(GAP_CLKS - 1);

    typedef enum logic [1:0] {
        IDLE,
        PREAMBLE,
        DATA,
        GAP
    } state_t;

    state_t           state_q, state_d;
    logic [CNT_W-1:0] cnt_q, cnt_d;
    logic             txen_q, txen_d;
    dibit_t           txd_q, txd_d;
    logic             last_q, last_d;
    byte_t            shreg_q, shreg_d;
    byte_t            hold_q, hold_d;
    byte_t            pre_byte;
    logic             take;

    // ready in idle follows valid, in data only on the fourth dibit
    assign o_ready = ((state_q == IDLE) && i_valid)
                  || ((state_q == DATA) && (cnt_q[1:0] == 2'b11) && !last_q);
    assign take    = i_valid && o_ready;

    // last preamble slot carries the delimiter instead
    assign pre_byte = (cnt_q == SFD_LOAD) ? SFD_BYTE : PREAMBLE_BYTE;

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q + 1'b1;
        txen_d  = txen_q;
        txd_d   = shreg_q[1:0];
        shreg_d = {2'b00, shreg_q[7:2]};
        hold_d  = hold_q;
        last_d  = last_q;
        case (state_q)
            IDLE: begin
                cnt_d = '0;
                txd_d = 2'b00;
                if (take) begin
                    // first byte waits in hold while the preamble goes out
                    state_d = PREAMBLE;
                    txen_d  = 1'b1;
                    txd_d   = PREAMBLE_BYTE[1:0];
                    shreg_d = {2'b00, PREAMBLE_BYTE[7:2]};
                    hold_d  = i_beat.data;
                    last_d  = i_beat.last;
                end
            end
            PREAMBLE: begin
                if (cnt_q == PRE_LAST) begin
                    state_d = DATA;
                    cnt_d   = '0;
                    txd_d   = hold_q[1:0];
                    shreg_d = {2'b00, hold_q[7:2]};
                end else if (cnt_q[1:0] == 2'b11) begin
                    // reload serializer with the next preamble octet
                    txd_d   = pre_byte[1:0];
                    shreg_d = {2'b00, pre_byte[7:2]};
                end
            end
            DATA: begin
                if (cnt_q[1:0] == 2'b11) begin
                    cnt_d = '0;
                    if (take) begin
                        txd_d   = i_beat.data[1:0];
                        shreg_d = {2'b00, i_beat.data[7:2]};
                        last_d  = i_beat.last;
                    end else begin
                        // last byte sent or source ran dry
                        state_d = GAP;
                        txen_d  = 1'b0;
                        txd_d   = 2'b00;
                    end
                end
            end
            GAP: begin
                txd_d = 2'b00;
                if (cnt_q == GAP_LAST) begin
                    state_d = IDLE;
                    cnt_d   = '0;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // --------------------------------------------------
    // registers
    // --------------------------------------------------
    always_ff @(posedge i_top or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            txen_q  <= 1'b0;
            txd_q   <= 2'b00;
            last_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
            txen_q  <= txen_d;
            txd_q   <= txd_d;
            last_q  <= last_d;
        end
    end

    always_ff @(posedge i_top) begin
        shreg_q <= shreg_d;
        hold_q  <= hold_d;
    end

    assign o_rmii = '{txen: txen_q, txd: txd_q};

endmodule
